// File: src/npu_pkg.sv
package npu_pkg;

    // Extended byte operand, used for weights and inputs
    localparam int OPERAND_W = 9;

    // Full signed product of two operands
    localparam int PRODUCT_W = 2 * OPERAND_W;

    // Width of the saturated column result
    localparam int RESULT_W = 16;

    // Signed operand, one lane of a weight or input vector
    typedef logic signed [OPERAND_W-1:0] operand_t;

    // Column command opcodes
    typedef enum logic [1:0] {
        // Idle slot, never sent with a strobe
        OP_NOP     = 2'd0,
        // Write weight vector into the shadow registers
        OP_PRELOAD = 2'd1,
        // Copy shadow weights into the active registers
        OP_SWAP    = 2'd2,
        // Push an input vector through the column
        OP_COMPUTE = 2'd3
    } npu_op_e;

    // Command port, single-cycle strobe
    typedef struct packed {
        logic    valid;
        npu_op_e op;
    } npu_cmd_t;

    // Result port, valid is a one-cycle strobe
    typedef struct packed {
        logic                       valid;
        // Set when the dot product was clipped
        logic                       sat;
        logic signed [RESULT_W-1:0] value;
    } npu_result_t;

endpackage

// File: src/npu_macc.sv
`timescale 1ns/1ps

module npu_macc #(
    parameter int LAST_SUM_WIDTH    = 0,
    parameter int PARTIAL_SUM_WIDTH = 18
) (
    input  logic                      clk_i,
    input  logic                      rstn_i,
    input  logic                      enable_i,
    // Shadow weight write strobe
    input  logic                      pre_wei_i,
    // Shadow to active weight copy strobe
    input  logic                      load_wei_i,
    input  npu_pkg::operand_t         wei_i,
    input  npu_pkg::operand_t         in_i,
    // Head cell keeps a 1-bit dummy port, tied off by the top level
    input  logic [(LAST_SUM_WIDTH > 0 ? LAST_SUM_WIDTH : 1)-1:0] last_sum_i,
    output logic [PARTIAL_SUM_WIDTH-1:0] part_sum_o
);

    import npu_pkg::*;

    // Double-buffered weight
    operand_t shadow_wei_q;
    operand_t active_wei_q;

    // Pipeline stage 1, registered input operand
    operand_t in_q;

    // Pipeline stage 2, registered signed product
    logic signed [PRODUCT_W-1:0] product_d;
    logic signed [PRODUCT_W-1:0] product_q;

    // Pipeline stage 3, accumulated partial sum
    logic signed [PARTIAL_SUM_WIDTH-1:0] product_ext;
    logic signed [PARTIAL_SUM_WIDTH-1:0] last_ext;
    logic signed [PARTIAL_SUM_WIDTH-1:0] part_sum_q;

    // Sum chain must be able to hold the incoming sum and a full product
    if (!(LAST_SUM_WIDTH == 0 || LAST_SUM_WIDTH <= PARTIAL_SUM_WIDTH)) begin : g_chk_last
        $error("npu_macc: LAST_SUM_WIDTH must be 0 or at most PARTIAL_SUM_WIDTH");
    end
    if (PARTIAL_SUM_WIDTH < PRODUCT_W) begin : g_chk_part
        $error("npu_macc: PARTIAL_SUM_WIDTH narrower than the product");
    end

    // 9x9 signed multiply, full 18-bit result
    assign product_d = in_q * active_wei_q;

    // Sign-extend both addends to the partial sum width
    assign product_ext = product_q;

    if (LAST_SUM_WIDTH > 0) begin : g_acc
        assign last_ext = $signed(last_sum_i);
    end else begin : g_head
        // First cell of the chain, product passes alone
        assign last_ext = '0;
    end

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            shadow_wei_q <= '0;
            active_wei_q <= '0;
            in_q         <= '0;
            product_q    <= '0;
            part_sum_q   <= '0;
        end else begin
            // Weights are loaded independently of the data enable
            if (pre_wei_i) begin
                shadow_wei_q <= wei_i;
            end
            if (load_wei_i) begin
                active_wei_q <= shadow_wei_q;
            end
            // Data path holds while the column is idle
            if (enable_i) begin
                in_q       <= in_i;
                product_q  <= product_d;
                part_sum_q <= product_ext + last_ext;
            end
        end
    end

    assign part_sum_o = part_sum_q;

endmodule

// File: src/npu_input_skew.sv
`timescale 1ns/1ps

module npu_input_skew #(
    parameter int N_CELLS = 4
) (
    input  logic                                clk_i,
    input  logic                                rstn_i,
    input  npu_pkg::npu_cmd_t                   cmd_i,
    input  npu_pkg::operand_t [N_CELLS-1:0]     data_i,
    // Weight vector, lane k goes to cell k
    output npu_pkg::operand_t [N_CELLS-1:0]     wei_o,
    // Skewed input vector, lane k goes to cell k
    output npu_pkg::operand_t [N_CELLS-1:0]     in_o,
    output logic                                pre_wei_o,
    output logic                                load_wei_o,
    output logic                                enable_o,
    // Last cell's sum is complete for one compute
    output logic                                done_o
);

    import npu_pkg::*;

    // Opcode decode
    logic is_preload;
    logic is_swap;
    logic is_compute;

    // Registered swap strobe, active weights move one edge later
    logic load_wei_q;

    // Compute marker aligned with lane 0, then one stage per skew step
    logic                 issue_q;
    logic [N_CELLS+1:0]   chain_q;
    logic                 in_flight;

    if (N_CELLS < 1) begin : g_chk_cells
        $error("npu_input_skew: N_CELLS must be at least 1");
    end

    assign is_preload = cmd_i.valid && (cmd_i.op == OP_PRELOAD);
    assign is_swap    = cmd_i.valid && (cmd_i.op == OP_SWAP);
    assign is_compute = cmd_i.valid && (cmd_i.op == OP_COMPUTE);

    // Preload writes shadows at the sampling edge itself
    assign wei_o     = data_i;
    assign pre_wei_o = is_preload;

    // Triangular skew, lane k passes k+1 registers
    for (genvar lane = 0; lane < N_CELLS; lane++) begin : g_lane
        operand_t dly_q [0:lane];

        always_ff @(posedge clk_i or negedge rstn_i) begin
            if (!rstn_i) begin
                for (int j = 0; j <= lane; j++) begin
                    dly_q[j] <= '0;
                end
            end else begin
                // Bubbles between computes carry zeros
                dly_q[0] <= is_compute ? data_i[lane] : '0;
                for (int j = 1; j <= lane; j++) begin
                    dly_q[j] <= dly_q[j-1];
                end
            end
        end

        assign in_o[lane] = dly_q[lane];
    end

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            load_wei_q <= 1'b0;
            issue_q    <= 1'b0;
            chain_q    <= '0;
        end else begin
            load_wei_q <= is_swap;
            issue_q    <= is_compute;
            // One stage per cycle, covers skew plus the 3-stage cells
            chain_q    <= {chain_q[N_CELLS:0], issue_q};
        end
    end

    assign in_flight  = issue_q || (|chain_q);
    assign load_wei_o = load_wei_q;
    assign enable_o   = is_compute || in_flight;
    assign done_o     = chain_q[N_CELLS+1];

    // Active weights must not change under an in-flight compute
    a_no_swap_in_flight: assert property (
        @(posedge clk_i) disable iff (!rstn_i)
        is_swap |-> !in_flight
    ) else $error("npu_input_skew: SWAP issued while a COMPUTE is in flight");

    // A strobe always carries a real opcode
    a_no_nop_strobe: assert property (
        @(posedge clk_i) disable iff (!rstn_i)
        cmd_i.valid |-> (cmd_i.op != OP_NOP)
    ) else $error("npu_input_skew: command strobe with OP_NOP");

endmodule

// File: src/npu_result_drain.sv
`timescale 1ns/1ps

module npu_result_drain #(
    parameter int SUM_W = 21
) (
    input  logic                 clk_i,
    input  logic                 rstn_i,
    input  logic                 done_i,
    input  logic [SUM_W-1:0]     sum_i,
    output npu_pkg::npu_result_t result_o
);

    import npu_pkg::*;

    // Clamp limits extended to the sum width
    localparam logic signed [SUM_W-1:0] SAT_MAX = SUM_W'((2 ** (RESULT_W - 1)) - 1);
    localparam logic signed [SUM_W-1:0] SAT_MIN = SUM_W'(-(2 ** (RESULT_W - 1)));

    logic signed [SUM_W-1:0]    sum_s;
    logic signed [RESULT_W-1:0] value_d;
    logic                       sat_d;
    npu_result_t                result_q;

    if (SUM_W < RESULT_W) begin : g_chk_width
        $error("npu_result_drain: SUM_W narrower than the result");
    end

    assign sum_s = sum_i;

    // Saturate to the 16-bit signed range
    always_comb begin
        sat_d   = 1'b0;
        value_d = sum_s[RESULT_W-1:0];
        if (sum_s > SAT_MAX) begin
            sat_d   = 1'b1;
            value_d = {1'b0, {(RESULT_W - 1){1'b1}}};
        end else if (sum_s < SAT_MIN) begin
            sat_d   = 1'b1;
            value_d = {1'b1, {(RESULT_W - 1){1'b0}}};
        end
    end

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            result_q <= '0;
        end else begin
            // Strobe follows done and the value holds in between
            result_q.valid <= done_i;
            if (done_i) begin
                result_q.sat   <= sat_d;
                result_q.value <= value_d;
            end
        end
    end

    assign result_o = result_q;

    // Unclipped results carry the full sum
    a_no_silent_clip: assert property (
        @(posedge clk_i) disable iff (!rstn_i)
        (result_o.valid && !result_o.sat) |-> (SUM_W'($signed(result_o.value)) == $past(sum_s))
    ) else $error("npu_result_drain: result clipped without sat");

endmodule

// File: src/npu_macc_column.sv
`timescale 1ns/1ps

module npu_macc_column #(
    parameter int N_CELLS = 4
) (
    input  logic                            clk_i,
    input  logic                            rstn_i,
    input  npu_pkg::npu_cmd_t               cmd_i,
    input  npu_pkg::operand_t [N_CELLS-1:0] data_i,
    output npu_pkg::npu_result_t            result_o
);

    import npu_pkg::*;

    // Final sum grows by one bit per cell after the first
    localparam int SUM_W = PRODUCT_W + N_CELLS - 1;

    // Feeder outputs shared by the cells
    operand_t [N_CELLS-1:0] wei;
    operand_t [N_CELLS-1:0] in_skew;
    logic                   pre_wei;
    logic                   load_wei;
    logic                   enable;
    logic                   done;

    npu_input_skew #(
        .N_CELLS(N_CELLS)
    ) u_input_skew (
        .clk_i      (clk_i),
        .rstn_i     (rstn_i),
        .cmd_i      (cmd_i),
        .data_i     (data_i),
        .wei_o      (wei),
        .in_o       (in_skew),
        .pre_wei_o  (pre_wei),
        .load_wei_o (load_wei),
        .enable_o   (enable),
        .done_o     (done)
    );

    // Cell k adds its product to cell k-1's partial sum
    for (genvar k = 0; k < N_CELLS; k++) begin : g_cell
        logic [PRODUCT_W+k-1:0] psum;

        if (k == 0) begin : g_head
            npu_macc #(
                .LAST_SUM_WIDTH    (0),
                .PARTIAL_SUM_WIDTH (PRODUCT_W)
            ) u_macc (
                .clk_i      (clk_i),
                .rstn_i     (rstn_i),
                .enable_i   (enable),
                .pre_wei_i  (pre_wei),
                .load_wei_i (load_wei),
                .wei_i      (wei[k]),
                .in_i       (in_skew[k]),
                .last_sum_i (1'b0),
                .part_sum_o (psum)
            );
        end else begin : g_tail
            npu_macc #(
                .LAST_SUM_WIDTH    (PRODUCT_W + k - 1),
                .PARTIAL_SUM_WIDTH (PRODUCT_W + k)
            ) u_macc (
                .clk_i      (clk_i),
                .rstn_i     (rstn_i),
                .enable_i   (enable),
                .pre_wei_i  (pre_wei),
                .load_wei_i (load_wei),
                .wei_i      (wei[k]),
                .in_i       (in_skew[k]),
                .last_sum_i (g_cell[k-1].psum),
                .part_sum_o (psum)
            );
        end
    end

    npu_result_drain #(
        .SUM_W(SUM_W)
    ) u_result_drain (
        .clk_i    (clk_i),
        .rstn_i   (rstn_i),
        .done_i   (done),
        .sum_i    (g_cell[N_CELLS-1].psum),
        .result_o (result_o)
    );

endmodule

// File: test/npu_tb_vectors.svh
`ifndef NPU_TB_VECTORS_SVH
`define NPU_TB_VECTORS_SVH

// add_cmd columns: opcode, lane 0 to lane 3, idle cycles after
// add_compute columns: lane 0 to lane 3, idle cycles after, expected value, expected sat
task automatic load_table();
    // Mixed-sign weights
    add_cmd(OP_PRELOAD, 3, -2, 5, 7, 0);
    add_cmd(OP_SWAP, 0, 0, 0, 0, 0);
    // Lone compute, gap keeps it isolated
    add_compute(1, 2, 3, 4, 8, 42, 1'b0);
    // Negative inputs, issued back to back
    add_compute(-10, 20, -30, 40, 0, 60, 1'b0);
    add_compute(100, -100, 50, -50, 0, 400, 1'b0);
    // Shadow load while the computes above are in flight
    add_cmd(OP_PRELOAD, -1, -1, -1, -1, 0);
    // Still the old active weights
    add_compute(1, 2, 3, 4, 0, 42, 1'b0);
    add_cmd(OP_SWAP, 0, 0, 0, 0, 0);
    // Four in a row with the new weights
    add_compute(1, 2, 3, 4, 0, -10, 1'b0);
    add_compute(-7, 8, -9, 10, 0, -2, 1'b0);
    add_compute(255, 0, 0, 0, 0, -255, 1'b0);
    add_compute(-256, -256, -256, -256, 4, 1024, 1'b0);
    // Most negative weights
    add_cmd(OP_PRELOAD, -256, -256, -256, -256, 0);
    add_cmd(OP_SWAP, 0, 0, 0, 0, 0);
    add_compute(-256, -256, -256, -256, 0, 32767, 1'b1);
    add_compute(255, 255, 255, 255, 0, -32768, 1'b1);
    add_compute(1, 0, 0, 0, 0, -256, 1'b0);
    // Just below, just above and exactly at the limits
    add_compute(-32, -32, -32, -31, 0, 32512, 1'b0);
    add_compute(-32, -32, -32, -32, 0, 32767, 1'b1);
    add_compute(32, 32, 32, 32, 0, -32768, 1'b0);
    // Most positive weights
    add_cmd(OP_PRELOAD, 255, 255, 255, 255, 0);
    add_cmd(OP_SWAP, 0, 0, 0, 0, 0);
    add_compute(255, 255, 255, 255, 0, 32767, 1'b1);
    add_compute(-256, -256, -256, -256, 2, -32768, 1'b1);
endtask

`endif

// File: test/tb_npu_column.sv
`timescale 1ns/1ps

module tb_npu_column;

    import npu_pkg::*;

    localparam int N_CELLS      = 4;
    localparam int RESET_CYCLES = 16;
    localparam int NUM_RANDOM   = 200;
    localparam int RES_MAX      = (2 ** (RESULT_W - 1)) - 1;
    localparam int RES_MIN      = -(2 ** (RESULT_W - 1));

    typedef operand_t [N_CELLS-1:0] vec_t;

    // One stimulus row, expected result only for table computes
    typedef struct {
        npu_op_e     op;
        vec_t        data;
        int          gap;
        bit          has_exp;
        npu_result_t exp;
    } row_t;

    // Expected result and the cycle it must show up
    typedef struct {
        npu_result_t exp;
        int          due;
    } pending_t;

    logic        clk  = 1'b0;
    logic        rstn;
    npu_cmd_t    cmd;
    vec_t        data;
    npu_result_t result;

    row_t        rows[$];
    pending_t    exp_q[$];
    // Weights as the bench believes them to be
    vec_t        shadow_w;
    vec_t        active_w;
    logic [31:0] rng_state      = 32'd13;
    int          cycle_cnt      = 0;
    int          timeout_cycles = 1000000;
    int          err_value      = 0;
    int          err_strobe     = 0;
    int          err_model      = 0;

    npu_macc_column #(
        .N_CELLS(N_CELLS)
    ) UUT (
        .clk_i    (clk),
        .rstn_i   (rstn),
        .cmd_i    (cmd),
        .data_i   (data),
        .result_o (result)
    );

    // 40 ns period
    always #20 clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] next_random();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    function automatic vec_t random_vector();
        vec_t        v;
        logic [31:0] r;
        for (int k = 0; k < N_CELLS; k++) begin
            r = next_random();
            v[k] = r[OPERAND_W-1:0];
        end
        return v;
    endfunction

    function automatic vec_t make_vec(input int d0, input int d1, input int d2, input int d3);
        vec_t v;
        v    = '0;
        v[0] = operand_t'(d0);
        v[1] = operand_t'(d1);
        v[2] = operand_t'(d2);
        v[3] = operand_t'(d3);
        return v;
    endfunction

    // Reference model, plain signed dot product then clamp
    function automatic npu_result_t dot_product(input vec_t w, input vec_t x);
        npu_result_t r;
        int          sum;
        sum = 0;
        for (int k = 0; k < N_CELLS; k++) begin
            sum += int'(w[k]) * int'(x[k]);
        end
        r.valid = 1'b1;
        r.sat   = (sum > RES_MAX) || (sum < RES_MIN);
        if (sum > RES_MAX) begin
            sum = RES_MAX;
        end else if (sum < RES_MIN) begin
            sum = RES_MIN;
        end
        r.value = sum[RESULT_W-1:0];
        return r;
    endfunction

    task automatic push_row(input npu_op_e op, input vec_t v, input int gap,
                            input bit has_exp, input npu_result_t exp);
        row_t r;
        r.op      = op;
        r.data    = v;
        r.gap     = gap;
        r.has_exp = has_exp;
        r.exp     = exp;
        rows.push_back(r);
    endtask

    task automatic add_cmd(input npu_op_e op, input int d0, input int d1, input int d2,
                           input int d3, input int gap);
        push_row(op, make_vec(d0, d1, d2, d3), gap, 1'b0, '0);
    endtask

    task automatic add_compute(input int d0, input int d1, input int d2, input int d3,
                               input int gap, input int exp_value, input bit exp_sat);
        npu_result_t e;
        e.valid = 1'b1;
        e.sat   = exp_sat;
        e.value = exp_value[RESULT_W-1:0];
        push_row(OP_COMPUTE, make_vec(d0, d1, d2, d3), gap, 1'b1, e);
    endtask

    `include "npu_tb_vectors.svh"

    // Random weights, random gaps, one shadow load mid-stream
    task automatic build_random_rows();
        int gap;
        push_row(OP_PRELOAD, random_vector(), 0, 1'b0, '0);
        push_row(OP_SWAP, '0, 0, 1'b0, '0);
        for (int i = 0; i < NUM_RANDOM; i++) begin
            if (i == NUM_RANDOM / 2) begin
                push_row(OP_PRELOAD, random_vector(), 0, 1'b0, '0);
            end
            if (i == (3 * NUM_RANDOM) / 4) begin
                push_row(OP_SWAP, '0, 0, 1'b0, '0);
            end
            gap = int'(next_random() % 32'd4);
            push_row(OP_COMPUTE, random_vector(), gap, 1'b0, '0);
        end
    endtask

    function automatic int compute_timeout();
        int limit;
        limit = RESET_CYCLES + N_CELLS + 3 + 50 + 2 * (N_CELLS + 4);
        foreach (rows[i]) begin
            limit += 1 + rows[i].gap;
            // Swaps wait for the column to drain
            if (rows[i].op == OP_SWAP) begin
                limit += N_CELLS + 6;
            end
        end
        return limit;
    endfunction

    task automatic check_result(input npu_result_t got, input npu_result_t exp);
        if (got.valid !== 1'b1) begin
            err_strobe++;
            $display("[ERROR] %0t ns: result_o.valid got %0b expected 1", $time, got.valid);
        end
        if (got.value !== exp.value) begin
            err_value++;
            $display("[ERROR] %0t ns: result_o.value got %0d expected %0d",
                     $time, got.value, exp.value);
        end
        if (got.sat !== exp.sat) begin
            err_value++;
            $display("[ERROR] %0t ns: result_o.sat got %0b expected %0b",
                     $time, got.sat, exp.sat);
        end
    endtask

    task automatic check_idle(input npu_result_t got);
        if (got.valid !== 1'b0) begin
            err_strobe++;
            $display("[ERROR] %0t ns: result_o.valid got %0b expected 0", $time, got.valid);
        end
    endtask

    // One command strobe, model updated in step
    task automatic send_cmd(input row_t r, input int idx);
        npu_result_t model;
        pending_t    p;
        @(negedge clk);
        cmd.valid = 1'b1;
        cmd.op    = r.op;
        data      = r.data;
        case (r.op)
            OP_PRELOAD: shadow_w = r.data;
            OP_SWAP:    active_w = shadow_w;
            OP_COMPUTE: begin
                model = dot_product(active_w, r.data);
                if (r.has_exp && (model !== r.exp)) begin
                    err_model++;
                    $display("Row %0d: table expects %0d sat %0b but the model gives %0d sat %0b",
                             idx, r.exp.value, r.exp.sat, model.value, model.sat);
                end
                p.exp = r.has_exp ? r.exp : model;
                // Sampling edge plus N_CELLS+3 edges
                p.due = cycle_cnt + N_CELLS + 4;
                exp_q.push_back(p);
            end
            default: ;
        endcase
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(negedge clk);
            cmd  = '0;
            data = '0;
        end
    endtask

    // Block until every expected result has come out
    task automatic wait_drain();
        idle_cycles(1);
        @(posedge clk);
        while (exp_q.size() != 0) begin
            @(posedge clk);
        end
    endtask

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    always @(posedge clk) begin
        if (cycle_cnt >= timeout_cycles) begin
            $display("Timeout after %0d cycles with %0d results still missing",
                     cycle_cnt, exp_q.size());
            $display("TEST FAILED");
            $finish;
        end
    end

    // Exact-cycle result check, anything else must be idle
    always @(negedge clk) begin
        if ((exp_q.size() != 0) && (exp_q[0].due == cycle_cnt)) begin
            check_result(result, exp_q[0].exp);
            void'(exp_q.pop_front());
        end else begin
            check_idle(result);
        end
    end

    initial begin
        int total;
        rstn     = 1'b0;
        cmd      = '0;
        data     = '0;
        shadow_w = '0;
        active_w = '0;
        load_table();
        build_random_rows();
        timeout_cycles = compute_timeout();
        repeat (RESET_CYCLES) @(negedge clk);
        rstn = 1'b1;
        foreach (rows[i]) begin
            // Swap only on an empty column
            if (rows[i].op == OP_SWAP) begin
                wait_drain();
            end
            send_cmd(rows[i], i);
            idle_cycles(rows[i].gap);
        end
        wait_drain();
        // Quiet tail, no stray strobes
        idle_cycles(N_CELLS + 4);
        total = err_value + err_strobe + err_model;
        $display("Errors: value %0d, strobe %0d, model %0d, total %0d",
                 err_value, err_strobe, err_model, total);
        if (total == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// File: all.f
+incdir+test
src/npu_pkg.sv
src/npu_macc.sv
src/npu_input_skew.sv
src/npu_result_drain.sv
src/npu_macc_column.sv
test/tb_npu_column.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    := --binary --timing --assert -Wno-fatal
TOP       := tb_npu_column
FILELIST  := all.f
BUILD_DIR := obj_dir
LOG       := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^TEST OK$$" $(LOG) || (echo "Simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
